// File: src/rvseed_defines.svh
// rvseed core widths, major opcodes and instruction field positions
`ifndef RVSEED_DEFINES_SVH
`define RVSEED_DEFINES_SVH

`define CPU_WIDTH       64        // data path
`define INST_WIDTH      32
`define REG_ADDR_WIDTH  5
`define REG_DATA_DEPTH  32        // x0..x31
`define SHAMT_WIDTH     6         // rv64 shift amount
`define IMM_WIDTH       12        // i-type immediate
`define ALU_OP_WIDTH    4

// major opcodes kept by this core
`define OPCODE_OP       7'b0110011
`define OPCODE_OP_IMM   7'b0010011

// funct7 patterns
`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000  // sub / sra

// field positions inside the instruction word
`define OPCODE_FIELD    6:0
`define RD_FIELD        11:7
`define FUNCT3_FIELD    14:12
`define RS1_FIELD       19:15
`define RS2_FIELD       24:20
`define FUNCT7_FIELD    31:25
`define IMM_FIELD       31:20
`define SHAMT_FIELD     25:20

`endif

// File: src/rvseed_pkg.sv
// rvseed shared types: alu operation and major opcode enums
`include "rvseed_defines.svh"

package rvseed_pkg;

  // operation carried from decode to execute
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,  // signed compare
    ALU_SLTU = 4'd9   // unsigned compare
  } alu_op_e;

  // major opcode classes, anything else is unknown
  typedef enum logic [6:0] {
    OPC_OP      = `OPCODE_OP,      // register-register
    OPC_OP_IMM  = `OPCODE_OP_IMM,  // register-immediate
    OPC_UNKNOWN = 7'b0000000
  } opcode_e;

endpackage

// File: src/regfile.sv
// regfile: 32 x 64 architectural registers, two async read ports, one write port
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module regfile (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic [`REG_ADDR_WIDTH-1:0]   rs1_addr_i,
  input  logic [`REG_ADDR_WIDTH-1:0]   rs2_addr_i,
  input  logic                         wen_i,
  input  logic [`REG_ADDR_WIDTH-1:0]   waddr_i,
  input  logic [`CPU_WIDTH-1:0]        wdata_i,
  output logic [`CPU_WIDTH-1:0]        rs1_data_o,
  output logic [`CPU_WIDTH-1:0]        rs2_data_o
);

  logic [`CPU_WIDTH-1:0] regs [0:`REG_DATA_DEPTH-1];

  // decode never raises wen for rd == x0, so x0 stays at its reset value
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `REG_DATA_DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // combinational reads, new value visible the cycle after the write edge
  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

endmodule

// File: src/id_stage.sv
// id stage: rv64i alu decode, operand read with execute forwarding, immediate select
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module id_stage (
  input  logic                         inst_valid_i,
  input  logic [`INST_WIDTH-1:0]       inst_i,
  input  logic [`CPU_WIDTH-1:0]        rs1_data_i,
  input  logic [`CPU_WIDTH-1:0]        rs2_data_i,
  input  logic                         ex_wen_i,     // instruction now in execute
  input  logic [`REG_ADDR_WIDTH-1:0]   ex_waddr_i,
  input  logic [`CPU_WIDTH-1:0]        ex_result_i,
  output logic [`REG_ADDR_WIDTH-1:0]   rs1_addr_o,
  output logic [`REG_ADDR_WIDTH-1:0]   rs2_addr_o,
  output logic                         dec_valid_o,
  output rvseed_pkg::alu_op_e          dec_alu_op_o,
  output logic [`CPU_WIDTH-1:0]        dec_src1_o,
  output logic [`CPU_WIDTH-1:0]        dec_src2_o,
  output logic                         dec_wen_o,
  output logic [`REG_ADDR_WIDTH-1:0]   dec_waddr_o,
  output logic                         dec_unknown_o
);

  rvseed_pkg::opcode_e          opcode;
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  logic [`REG_ADDR_WIDTH-1:0]   rd;
  logic                         unknown;
  logic                         use_imm;   // src2 from immediate
  logic                         shift_imm; // slli / srli / srai take shamt
  logic [`CPU_WIDTH-1:0]        imm;
  logic [`CPU_WIDTH-1:0]        rs1_val;
  logic [`CPU_WIDTH-1:0]        rs2_val;

  assign funct3     = inst_i[`FUNCT3_FIELD];
  assign funct7     = inst_i[`FUNCT7_FIELD];
  assign rd         = inst_i[`RD_FIELD];
  assign rs1_addr_o = inst_i[`RS1_FIELD];
  assign rs2_addr_o = inst_i[`RS2_FIELD];  // don't care for op-imm

  // fold raw opcode onto the kept classes
  assign opcode = (inst_i[`OPCODE_FIELD] == `OPCODE_OP)     ? rvseed_pkg::OPC_OP :
                  (inst_i[`OPCODE_FIELD] == `OPCODE_OP_IMM) ? rvseed_pkg::OPC_OP_IMM :
                                                              rvseed_pkg::OPC_UNKNOWN;

  always_comb begin
    unknown      = 1'b0;
    use_imm      = 1'b0;
    dec_alu_op_o = rvseed_pkg::ALU_ADD;
    case (opcode)
      rvseed_pkg::OPC_OP: begin
        if (funct7 == `FUNCT7_BASE) begin
          case (funct3)
            3'b000: dec_alu_op_o = rvseed_pkg::ALU_ADD;
            3'b001: dec_alu_op_o = rvseed_pkg::ALU_SLL;
            3'b010: dec_alu_op_o = rvseed_pkg::ALU_SLT;
            3'b011: dec_alu_op_o = rvseed_pkg::ALU_SLTU;
            3'b100: dec_alu_op_o = rvseed_pkg::ALU_XOR;
            3'b101: dec_alu_op_o = rvseed_pkg::ALU_SRL;
            3'b110: dec_alu_op_o = rvseed_pkg::ALU_OR;
            3'b111: dec_alu_op_o = rvseed_pkg::ALU_AND;
          endcase
        end else if (funct7 == `FUNCT7_ALT && funct3 == 3'b000) begin
          dec_alu_op_o = rvseed_pkg::ALU_SUB;
        end else if (funct7 == `FUNCT7_ALT && funct3 == 3'b101) begin
          dec_alu_op_o = rvseed_pkg::ALU_SRA;
        end else begin
          unknown = 1'b1;  // any other funct7
        end
      end
      rvseed_pkg::OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000: dec_alu_op_o = rvseed_pkg::ALU_ADD;
          3'b010: dec_alu_op_o = rvseed_pkg::ALU_SLT;
          3'b011: dec_alu_op_o = rvseed_pkg::ALU_SLTU;
          3'b100: dec_alu_op_o = rvseed_pkg::ALU_XOR;
          3'b110: dec_alu_op_o = rvseed_pkg::ALU_OR;
          3'b111: dec_alu_op_o = rvseed_pkg::ALU_AND;
          3'b001: begin
            if (funct7[6:1] == 6'b000000) dec_alu_op_o = rvseed_pkg::ALU_SLL;
            else                          unknown = 1'b1;
          end
          3'b101: begin
            // bit 25 belongs to the 6-bit shamt on rv64
            if (funct7[6:1] == 6'b000000)      dec_alu_op_o = rvseed_pkg::ALU_SRL;
            else if (funct7[6:1] == 6'b010000) dec_alu_op_o = rvseed_pkg::ALU_SRA;
            else                               unknown = 1'b1;
          end
        endcase
      end
      default: unknown = 1'b1;  // loads, branches, system, zero word
    endcase
  end

  assign shift_imm = (funct3 == 3'b001) || (funct3 == 3'b101);
  assign imm = shift_imm ?
               {{(`CPU_WIDTH-`SHAMT_WIDTH){1'b0}}, inst_i[`SHAMT_FIELD]} :
               {{(`CPU_WIDTH-`IMM_WIDTH){inst_i[`INST_WIDTH-1]}}, inst_i[`IMM_FIELD]};

  // bypass the result still in execute, regfile write lands one edge later
  assign rs1_val = (ex_wen_i && ex_waddr_i != '0 && ex_waddr_i == rs1_addr_o) ?
                   ex_result_i : rs1_data_i;
  assign rs2_val = (ex_wen_i && ex_waddr_i != '0 && ex_waddr_i == rs2_addr_o) ?
                   ex_result_i : rs2_data_i;

  assign dec_valid_o   = inst_valid_i;
  assign dec_src1_o    = rs1_val;
  assign dec_src2_o    = use_imm ? imm : rs2_val;
  assign dec_wen_o     = !unknown && (rd != '0);  // keeps x0 at zero
  assign dec_waddr_o   = rd;
  assign dec_unknown_o = unknown;

endmodule

// File: src/id_ex_regs.sv
// id/ex pipeline register: decoded operation, operands and control between decode and execute
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module id_ex_regs (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic                         dec_valid_i,
  input  rvseed_pkg::alu_op_e          dec_alu_op_i,
  input  logic [`CPU_WIDTH-1:0]        dec_src1_i,
  input  logic [`CPU_WIDTH-1:0]        dec_src2_i,
  input  logic                         dec_wen_i,
  input  logic [`REG_ADDR_WIDTH-1:0]   dec_waddr_i,
  input  logic                         dec_unknown_i,
  output logic                         ex_valid_o,
  output rvseed_pkg::alu_op_e          ex_alu_op_o,
  output logic [`CPU_WIDTH-1:0]        ex_src1_o,
  output logic [`CPU_WIDTH-1:0]        ex_src2_o,
  output logic                         ex_wen_o,
  output logic [`REG_ADDR_WIDTH-1:0]   ex_waddr_o,
  output logic                         ex_unknown_o
);

  // control, bubble cycles never look like a write or an unknown
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o   <= 1'b0;
      ex_wen_o     <= 1'b0;
      ex_unknown_o <= 1'b0;
    end else begin
      ex_valid_o   <= dec_valid_i;
      ex_wen_o     <= dec_valid_i & dec_wen_i;
      ex_unknown_o <= dec_valid_i & dec_unknown_i;
    end
  end

  // payload, taken every cycle
  always_ff @(posedge clk) begin
    ex_alu_op_o <= dec_alu_op_i;
    ex_src1_o   <= dec_src1_i;
    ex_src2_o   <= dec_src2_i;
    ex_waddr_o  <= dec_waddr_i;
  end

endmodule

// File: src/ex_stage.sv
// ex stage: 64-bit alu and registered commit outputs
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module ex_stage (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic                         ex_valid_i,
  input  rvseed_pkg::alu_op_e          ex_alu_op_i,
  input  logic [`CPU_WIDTH-1:0]        ex_src1_i,
  input  logic [`CPU_WIDTH-1:0]        ex_src2_i,
  input  logic                         ex_wen_i,     // already gated by valid
  input  logic [`REG_ADDR_WIDTH-1:0]   ex_waddr_i,
  input  logic                         ex_unknown_i,
  output logic [`CPU_WIDTH-1:0]        ex_result_o,  // to decode bypass and regfile
  output logic                         cmt_valid_o,
  output logic                         cmt_unknown_o,
  output logic                         cmt_wen_o,
  output logic [`REG_ADDR_WIDTH-1:0]   cmt_waddr_o,
  output logic [`CPU_WIDTH-1:0]        cmt_wdata_o
);

  logic [`SHAMT_WIDTH-1:0] shamt;

  assign shamt = ex_src2_i[`SHAMT_WIDTH-1:0];  // low 6 bits only

  always_comb begin
    case (ex_alu_op_i)
      rvseed_pkg::ALU_ADD:  ex_result_o = ex_src1_i + ex_src2_i;
      rvseed_pkg::ALU_SUB:  ex_result_o = ex_src1_i - ex_src2_i;
      rvseed_pkg::ALU_AND:  ex_result_o = ex_src1_i & ex_src2_i;
      rvseed_pkg::ALU_OR:   ex_result_o = ex_src1_i | ex_src2_i;
      rvseed_pkg::ALU_XOR:  ex_result_o = ex_src1_i ^ ex_src2_i;
      rvseed_pkg::ALU_SLL:  ex_result_o = ex_src1_i << shamt;
      rvseed_pkg::ALU_SRL:  ex_result_o = ex_src1_i >> shamt;
      rvseed_pkg::ALU_SRA:  ex_result_o = $signed(ex_src1_i) >>> shamt;  // fill with sign
      rvseed_pkg::ALU_SLT:
        ex_result_o = {{(`CPU_WIDTH-1){1'b0}}, $signed(ex_src1_i) < $signed(ex_src2_i)};
      rvseed_pkg::ALU_SLTU:
        ex_result_o = {{(`CPU_WIDTH-1){1'b0}}, ex_src1_i < ex_src2_i};
      default: ex_result_o = '0;
    endcase
  end

  // commit strobe and flags
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmt_valid_o   <= 1'b0;
      cmt_wen_o     <= 1'b0;
      cmt_unknown_o <= 1'b0;
    end else begin
      cmt_valid_o   <= ex_valid_i;
      cmt_wen_o     <= ex_wen_i;
      cmt_unknown_o <= ex_unknown_i;
    end
  end

  // commit payload, only meaningful with cmt_valid_o
  always_ff @(posedge clk) begin
    cmt_waddr_o <= ex_waddr_i;
    cmt_wdata_o <= ex_result_o;
  end

endmodule

// File: src/cpu.sv
// cpu top: decode, id/ex register, execute and regfile for the rv64i alu subset
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module cpu (
  input  logic                         clk,
  input  logic                         arst_n_i,
  input  logic                         inst_valid_i,  // one-cycle strobe, no ready
  input  logic [`INST_WIDTH-1:0]       inst_i,
  output logic                         cmt_valid_o,
  output logic                         cmt_unknown_o,
  output logic                         cmt_wen_o,
  output logic [`REG_ADDR_WIDTH-1:0]   cmt_waddr_o,
  output logic [`CPU_WIDTH-1:0]        cmt_wdata_o
);

  // regfile read side
  logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
  logic [`CPU_WIDTH-1:0]      rs1_data;
  logic [`CPU_WIDTH-1:0]      rs2_data;

  // decode outputs
  logic                       dec_valid;
  rvseed_pkg::alu_op_e        dec_alu_op;
  logic [`CPU_WIDTH-1:0]      dec_src1;
  logic [`CPU_WIDTH-1:0]      dec_src2;
  logic                       dec_wen;
  logic [`REG_ADDR_WIDTH-1:0] dec_waddr;
  logic                       dec_unknown;

  // execute inputs
  logic                       ex_valid;
  rvseed_pkg::alu_op_e        ex_alu_op;
  logic [`CPU_WIDTH-1:0]      ex_src1;
  logic [`CPU_WIDTH-1:0]      ex_src2;
  logic                       ex_wen;
  logic [`REG_ADDR_WIDTH-1:0] ex_waddr;
  logic                       ex_unknown;
  logic [`CPU_WIDTH-1:0]      ex_result;

  // writeback lands on the same edge the commit registers load
  logic                       wb_wen;
  logic [`REG_ADDR_WIDTH-1:0] wb_waddr;
  logic [`CPU_WIDTH-1:0]      wb_wdata;

  assign wb_wen   = ex_wen;
  assign wb_waddr = ex_waddr;
  assign wb_wdata = ex_result;

  regfile u_regfile (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wen_i      (wb_wen),
    .waddr_i    (wb_waddr),
    .wdata_i    (wb_wdata),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  id_stage u_id_stage (
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .ex_wen_i      (ex_wen),      // bypass source
    .ex_waddr_i    (ex_waddr),
    .ex_result_i   (ex_result),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .dec_valid_o   (dec_valid),
    .dec_alu_op_o  (dec_alu_op),
    .dec_src1_o    (dec_src1),
    .dec_src2_o    (dec_src2),
    .dec_wen_o     (dec_wen),
    .dec_waddr_o   (dec_waddr),
    .dec_unknown_o (dec_unknown)
  );

  id_ex_regs u_id_ex_regs (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .dec_valid_i   (dec_valid),
    .dec_alu_op_i  (dec_alu_op),
    .dec_src1_i    (dec_src1),
    .dec_src2_i    (dec_src2),
    .dec_wen_i     (dec_wen),
    .dec_waddr_i   (dec_waddr),
    .dec_unknown_i (dec_unknown),
    .ex_valid_o    (ex_valid),
    .ex_alu_op_o   (ex_alu_op),
    .ex_src1_o     (ex_src1),
    .ex_src2_o     (ex_src2),
    .ex_wen_o      (ex_wen),
    .ex_waddr_o    (ex_waddr),
    .ex_unknown_o  (ex_unknown)
  );

  ex_stage u_ex_stage (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .ex_valid_i    (ex_valid),
    .ex_alu_op_i   (ex_alu_op),
    .ex_src1_i     (ex_src1),
    .ex_src2_i     (ex_src2),
    .ex_wen_i      (ex_wen),
    .ex_waddr_i    (ex_waddr),
    .ex_unknown_i  (ex_unknown),
    .ex_result_o   (ex_result),
    .cmt_valid_o   (cmt_valid_o),
    .cmt_unknown_o (cmt_unknown_o),
    .cmt_wen_o     (cmt_wen_o),
    .cmt_waddr_o   (cmt_waddr_o),
    .cmt_wdata_o   (cmt_wdata_o)
  );

endmodule

// File: dv/cpu_props.sv
// cpu_props: commit latency, reset and write-enable rules checked on the cpu ports
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module cpu_props (
  input logic                         clk,
  input logic                         arst_n_i,
  input logic                         inst_valid_i,
  input logic                         cmt_valid_i,
  input logic                         cmt_unknown_i,
  input logic                         cmt_wen_i,
  input logic [`REG_ADDR_WIDTH-1:0]   cmt_waddr_i
);

  // strobe to commit, two edges through id/ex and the commit regs
  latency_a : assert property (@(posedge clk) disable iff (!arst_n_i)
    inst_valid_i |-> ##2 cmt_valid_i)
    else $error("commit missing two cycles after strobe");

  reset_a : assert property (@(posedge clk) !arst_n_i |-> !cmt_valid_i)
    else $error("commit valid while in reset");

  // only known instructions with a real rd write
  wen_a : assert property (@(posedge clk) disable iff (!arst_n_i)
    cmt_wen_i |-> (cmt_waddr_i != '0) && !cmt_unknown_i)
    else $error("write enable with x0 or unknown instruction");

endmodule

bind cpu cpu_props u_cpu_props (
  .clk           (clk),
  .arst_n_i      (arst_n_i),
  .inst_valid_i  (inst_valid_i),
  .cmt_valid_i   (cmt_valid_o),
  .cmt_unknown_i (cmt_unknown_o),
  .cmt_wen_i     (cmt_wen_o),
  .cmt_waddr_i   (cmt_waddr_o)
);

// File: dv/tb_cpu.sv
// tb_cpu: drives the rv64i alu core with directed and random instructions, checks every commit
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module tb_cpu;

  localparam int RAND_COUNT      = 300;
  localparam int DIRECTED_BUDGET = 120;  // directed instructions, rounded up
  // strobe plus at most two idle cycles per instruction, reset and drain on top
  localparam int CYCLE_LIMIT     = 4 + 3 * (DIRECTED_BUDGET + RAND_COUNT) + 50;

  logic                         clk;
  logic                         arst_n_i;
  logic                         inst_valid_i;
  logic [`INST_WIDTH-1:0]       inst_i;
  logic                         cmt_valid_o;
  logic                         cmt_unknown_o;
  logic                         cmt_wen_o;
  logic [`REG_ADDR_WIDTH-1:0]   cmt_waddr_o;
  logic [`CPU_WIDTH-1:0]        cmt_wdata_o;

  logic [`CPU_WIDTH-1:0] model_regs [0:`REG_DATA_DEPTH-1];  // architectural state
  logic [70:0]           exp_q [$];   // {unknown, wen, waddr, wdata}
  int                    sent_q [$];  // cycle of each strobe
  logic [70:0]           exp_cmt;
  int                    exp_cycle;
  int                    cycle_cnt;
  int                    errors;
  int                    commits;
  logic [31:0]           rng;
  logic [4:0]            last_rd;

  cpu UUT (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .cmt_valid_o   (cmt_valid_o),
    .cmt_unknown_o (cmt_unknown_o),
    .cmt_wen_o     (cmt_wen_o),
    .cmt_waddr_o   (cmt_waddr_o),
    .cmt_wdata_o   (cmt_wdata_o)
  );

  always #10 clk = ~clk;  // 20 ns period

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPCODE_OP};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `OPCODE_OP_IMM};
  endfunction

  // rv64i alu semantics applied to the model, returns the commit to expect
  function automatic logic [70:0] expected_commit(input logic [31:0] inst);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [5:0]  sh;
    logic        known;
    logic        wen;
    opc   = inst[6:0];
    f3    = inst[14:12];
    f7    = inst[31:25];
    rd    = inst[11:7];
    a     = model_regs[inst[19:15]];
    known = 1'b1;
    res   = '0;
    if (opc == rvseed_pkg::OPC_OP) begin
      b  = model_regs[inst[24:20]];
      sh = b[5:0];
      case ({f7, f3})
        {7'h00, 3'd0}: res = a + b;
        {7'h20, 3'd0}: res = a - b;
        {7'h00, 3'd1}: res = a << sh;
        {7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        {7'h00, 3'd3}: res = (a < b) ? 64'd1 : 64'd0;
        {7'h00, 3'd4}: res = a ^ b;
        {7'h00, 3'd5}: res = a >> sh;
        {7'h20, 3'd5}: res = $signed(a) >>> sh;
        {7'h00, 3'd6}: res = a | b;
        {7'h00, 3'd7}: res = a & b;
        default:       known = 1'b0;
      endcase
    end else if (opc == rvseed_pkg::OPC_OP_IMM) begin
      b  = {{52{inst[31]}}, inst[31:20]};  // sign extended imm12
      sh = inst[25:20];
      case (f3)
        3'd0: res = a + b;
        3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'd3: res = (a < b) ? 64'd1 : 64'd0;
        3'd4: res = a ^ b;
        3'd6: res = a | b;
        3'd7: res = a & b;
        3'd1: begin
          if (inst[31:26] == 6'b000000) res = a << sh;
          else known = 1'b0;
        end
        default: begin  // funct3 5, srli or srai
          if (inst[31:26] == 6'b000000) res = a >> sh;
          else if (inst[31:26] == 6'b010000) res = $signed(a) >>> sh;
          else known = 1'b0;
        end
      endcase
    end else begin
      known = 1'b0;  // any other major opcode
    end
    wen = known && (rd != 5'd0);
    if (wen) model_regs[rd] = res;
    return {!known, wen, rd, res};
  endfunction

  task automatic send_inst(input logic [31:0] inst);
    @(posedge clk);
    #2;
    inst_valid_i = 1'b1;
    inst_i       = inst;
    exp_q.push_back(expected_commit(inst));
    sent_q.push_back(cycle_cnt);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      inst_valid_i = 1'b0;
    end
  endtask

  task automatic random_stream(input int count);
    logic [31:0] r;
    logic [31:0] f;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [31:0] inst;
    for (int n = 0; n < count; n++) begin
      r   = next_rand();
      f   = next_rand();
      rs1 = r[8] ? last_rd : f[19:15];  // chain on the previous rd now and then
      f3  = r[6:4];
      if (r[3:0] < 4'd8) begin
        inst = r_word((r[7] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                      f[24:20], rs1, f3, f[11:7]);
      end else if (r[3:0] < 4'd14) begin
        if (f3 == 3'd1) imm = {6'b000000, f[25:20]};
        else if (f3 == 3'd5) imm = {r[7] ? 6'b010000 : 6'b000000, f[25:20]};
        else imm = f[31:20];
        inst = i_word(imm, rs1, f3, f[11:7]);
      end else if (r[3:0] == 4'd14) begin
        inst = {f[31:12], f[11:7], 7'b0000011};  // load opcode
      end else begin
        inst = r_word(7'h01, f[24:20], rs1, f3, f[11:7]);  // muldiv space
      end
      send_inst(inst);
      last_rd = f[11:7];
      if (r[10:9] == 2'b00) idle_cycles(1 + int'(r[11]));
    end
  endtask

  // cycle count and run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // compare at the falling edge, commit outputs are stable there
  always @(negedge clk) begin
    if (arst_n_i && cmt_valid_o) begin
      commits++;
      if (exp_q.size() == 0) begin
        $display("%0t a commit arrived with no instruction outstanding", $time);
        errors++;
      end else begin
        exp_cmt   = exp_q.pop_front();
        exp_cycle = sent_q.pop_front();
        assert (cycle_cnt == exp_cycle + 2) else begin
          $display("[FAIL] %0t commit cycle exp %0d got %0d", $time, exp_cycle + 2, cycle_cnt);
          errors++;
        end
        assert (cmt_unknown_o == exp_cmt[70]) else begin
          $display("[FAIL] %0t cmt_unknown_o exp %b got %b", $time, exp_cmt[70], cmt_unknown_o);
          errors++;
        end
        assert (cmt_wen_o == exp_cmt[69]) else begin
          $display("[FAIL] %0t cmt_wen_o exp %b got %b", $time, exp_cmt[69], cmt_wen_o);
          errors++;
        end
        assert (cmt_waddr_o == exp_cmt[68:64]) else begin
          $display("[FAIL] %0t cmt_waddr_o exp %0d got %0d", $time, exp_cmt[68:64], cmt_waddr_o);
          errors++;
        end
        // data only means something for a decoded instruction
        assert (exp_cmt[70] || cmt_wdata_o == exp_cmt[63:0]) else begin
          $display("[FAIL] %0t cmt_wdata_o exp %h got %h", $time, exp_cmt[63:0], cmt_wdata_o);
          errors++;
        end
      end
    end
  end

  initial begin
    clk          = 1'b0;
    arst_n_i     = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    cycle_cnt    = 0;
    errors       = 0;
    commits      = 0;
    rng          = 32'hd2b2ce4b;
    last_rd      = 5'd0;
    for (int i = 0; i < `REG_DATA_DEPTH; i++) model_regs[i] = '0;
    #1 arst_n_i = 1'b0;  // falling edge after time zero
    repeat (4) @(posedge clk);
    #2 arst_n_i = 1'b1;

    // addi into every register, mixed signs, then the ten r-type ops
    for (int r = 1; r < `REG_DATA_DEPTH; r++) send_inst(i_word(12'(r * 131), 5'd0, 3'd0, 5'(r)));
    idle_cycles(2);
    send_inst(r_word(7'h00, 5'd2, 5'd3, 3'd0, 5'd25));
    send_inst(r_word(7'h20, 5'd4, 5'd5, 3'd0, 5'd26));
    send_inst(r_word(7'h00, 5'd6, 5'd7, 3'd7, 5'd27));
    send_inst(r_word(7'h00, 5'd8, 5'd9, 3'd6, 5'd28));
    send_inst(r_word(7'h00, 5'd10, 5'd11, 3'd4, 5'd29));
    send_inst(r_word(7'h00, 5'd12, 5'd13, 3'd1, 5'd30));
    send_inst(r_word(7'h00, 5'd14, 5'd15, 3'd5, 5'd31));
    send_inst(r_word(7'h20, 5'd16, 5'd17, 3'd5, 5'd25));
    send_inst(r_word(7'h00, 5'd18, 5'd19, 3'd2, 5'd26));
    send_inst(r_word(7'h00, 5'd20, 5'd21, 3'd3, 5'd27));
    idle_cycles(2);

    // negative immediates, shifts to 63, signed vs unsigned compares
    send_inst(i_word(12'hfff, 5'd0, 3'd0, 5'd5));
    send_inst(i_word(12'h800, 5'd0, 3'd0, 5'd6));
    send_inst(i_word({6'b010000, 6'd63}, 5'd5, 3'd5, 5'd7));
    send_inst(i_word({6'b000000, 6'd63}, 5'd5, 3'd5, 5'd8));
    send_inst(i_word({6'b000000, 6'd40}, 5'd6, 3'd1, 5'd9));
    send_inst(i_word({6'b010000, 6'd5}, 5'd6, 3'd5, 5'd10));
    send_inst(i_word({6'b000000, 6'd5}, 5'd6, 3'd5, 5'd11));
    send_inst(r_word(7'h00, 5'd1, 5'd5, 3'd2, 5'd12));
    send_inst(r_word(7'h00, 5'd1, 5'd5, 3'd3, 5'd13));
    send_inst(i_word(12'h001, 5'd6, 3'd2, 5'd14));
    send_inst(i_word(12'hfff, 5'd6, 3'd3, 5'd15));
    send_inst(i_word(12'h555, 5'd5, 3'd4, 5'd16));
    send_inst(i_word(12'hf0f, 5'd6, 3'd6, 5'd17));
    send_inst(i_word(12'h8ff, 5'd5, 3'd7, 5'd18));
    send_inst(r_word(7'h20, 5'd16, 5'd6, 3'd5, 5'd19));
    idle_cycles(2);

    // back to back chains through rs1 and rs2, then one idle cycle between
    repeat (8) send_inst(r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd1));
    repeat (6) send_inst(r_word(7'h20, 5'd3, 5'd4, 3'd0, 5'd3));
    repeat (6) begin
      send_inst(i_word(12'h07f, 5'd20, 3'd0, 5'd20));
      idle_cycles(1);
    end

    // x0 as destination and as source right after
    send_inst(i_word(12'h123, 5'd1, 3'd0, 5'd0));
    send_inst(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd21));
    send_inst(r_word(7'h00, 5'd0, 5'd1, 3'd6, 5'd22));
    send_inst(i_word(12'h7ff, 5'd0, 3'd4, 5'd0));
    send_inst(r_word(7'h20, 5'd0, 5'd0, 3'd0, 5'd23));
    idle_cycles(2);

    // unknown words leave the state alone
    send_inst({12'h000, 5'd2, 3'd3, 5'd1, 7'b0000011});
    send_inst(r_word(7'h01, 5'd3, 5'd2, 3'd0, 5'd4));
    send_inst(32'h0000_0000);
    send_inst(r_word(7'h20, 5'd3, 5'd2, 3'd4, 5'd5));
    send_inst(r_word(7'h00, 5'd4, 5'd1, 3'd0, 5'd24));
    idle_cycles(2);

    random_stream(RAND_COUNT);
    idle_cycles(4);  // drain the pipe

    if (exp_q.size() != 0) begin
      $display("%0d expected commits never arrived", exp_q.size());
      errors++;
    end
    $display("checks done, %0d commits, %0d errors", commits, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+src
src/rvseed_pkg.sv
src/regfile.sv
src/id_stage.sv
src/id_ex_regs.sv
src/ex_stage.sv
src/cpu.sv
dv/cpu_props.sv
dv/tb_cpu.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_cpu
FILELIST := all.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
